//--- src/cpu_pkg.sv
package cpu_pkg;

    // ========================================
    // Sizes
    localparam logic [15:0] ORIGIN_ADDR = 16'h0000;    // PC after load_origin
    localparam int RAM_DEPTH = 256;
    localparam int RAM_ADDR_W = $clog2(RAM_DEPTH);
    localparam int NUM_MICROSTEPS = 8;
    localparam int MICROSTEP_W = $clog2(NUM_MICROSTEPS);

    // ========================================
    // Instruction set
    typedef enum logic [7:0] {
        NOP   = 8'h00,
        HLT   = 8'h01,
        ADD_B = 8'h02,
        ADD_C = 8'h03,
        SUB_B = 8'h04,
        SUB_C = 8'h05,
        INR_A = 8'h06,
        DCR_A = 8'h07,
        LDI_A = 8'h08,    // One operand byte
        LDI_B = 8'h09,
        LDI_C = 8'h0A,
        JMP   = 8'h0B,    // Two operand bytes with low byte first
        JZ    = 8'h0C,
        JNZ   = 8'h0D,
        JN    = 8'h0E,
        LDA   = 8'h0F
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_UNDEFINED = 3'd0,
        ALU_ADD       = 3'd1,
        ALU_SUB       = 3'd2,
        ALU_INC       = 3'd3,
        ALU_DEC       = 3'd4
    } alu_op_t;

    typedef enum logic [2:0] {
        S_RESET,
        S_INIT,
        S_LATCH_ADDR,
        S_READ_BYTE,
        S_LATCH_BYTE,
        S_CHK_MORE_BYTES,
        S_EXECUTE,
        S_HALT
    } fsm_state_t;

    typedef enum logic [MICROSTEP_W-1:0] {
        MS0, MS1, MS2, MS3, MS4, MS5, MS6, MS7
    } microstep_t;

    typedef struct packed {
        logic negative;
        logic carry;
        logic zero;       // Bit 0
    } flags_t;

    // ========================================
    // Control word
    typedef struct packed {
        logic    load_origin;
        logic    load_mar_pc;
        logic    load_mar_addr_low;
        logic    load_mar_addr_high;
        logic    load_ir;
        logic    load_temp_1;
        logic    load_temp_2;
        logic    load_a;
        logic    load_b;
        logic    load_c;
        logic    load_pc;            // Whole PC from temp_2:temp_1
        logic    load_flags;
        logic    pc_enable;
        logic    oe_ram;             // Only one bus driver set at a time
        logic    oe_temp_1;
        logic    oe_temp_2;
        logic    oe_alu;
        alu_op_t alu_op;
        logic    alu_src_c;          // ALU operand B from C instead of B
        logic    load_sets_zn;       // Z and N from bus value with carry kept
        logic    check_zero;
        logic    check_not_zero;
        logic    check_carry;
        logic    check_negative;
        logic    last_step;
        logic    halt;
    } control_word_t;

endpackage

//--- src/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [7:0]        a,
    input  logic [7:0]        b,
    input  cpu_pkg::alu_op_t  alu_op,
    output logic [7:0]        result,
    output cpu_pkg::flags_t   result_flags
);

    logic [8:0] wide;    // Bit 8 is carry out or borrow

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_ADD: wide = {1'b0, a} + {1'b0, b};
            cpu_pkg::ALU_SUB: wide = {1'b0, a} - {1'b0, b};
            cpu_pkg::ALU_INC: wide = {1'b0, a} + 9'd1;
            cpu_pkg::ALU_DEC: wide = {1'b0, a} - 9'd1;    // Borrow only from 0x00
            default:          wide = {1'b0, a};
        endcase
    end

    assign result                = wide[7:0];
    assign result_flags.negative = wide[7];
    assign result_flags.carry    = wide[8];
    assign result_flags.zero     = (wide[7:0] == 8'h00);

endmodule

//--- src/ram.sv
`timescale 1ns/1ps

module ram (
    input  logic                           clk,
    input  logic [15:0]                    addr,
    output logic [7:0]                     rdata,
    input  logic                           prog_we,
    input  logic [cpu_pkg::RAM_ADDR_W-1:0] prog_addr,
    input  logic [7:0]                     prog_data
);

    logic [7:0] mem [cpu_pkg::RAM_DEPTH];

    // Program load port only
    always_ff @(posedge clk) begin
        if (prog_we)
            mem[prog_addr] <= prog_data;
    end

    assign rdata = mem[addr[cpu_pkg::RAM_ADDR_W-1:0]];    // Upper address bits ignored

endmodule

//--- src/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic                   clk,
    input  logic                   reset,
    input  cpu_pkg::control_word_t control_word,
    input  logic [7:0]             mem_data,
    input  logic [7:0]             alu_result,
    input  cpu_pkg::flags_t        alu_flags,
    output logic [15:0]            mem_addr,
    output logic [7:0]             alu_a,
    output logic [7:0]             alu_b,
    output cpu_pkg::opcode_t       opcode,
    output cpu_pkg::flags_t        flags,
    output logic [7:0]             reg_a,
    output logic [7:0]             reg_b,
    output logic [7:0]             reg_c,
    output logic [15:0]            pc
);

    logic [7:0]  bus;
    logic [7:0]  temp_1;    // Operand low byte
    logic [7:0]  temp_2;    // Operand high byte
    logic [15:0] mar;

    // ========================================
    // Internal bus
    always_comb begin
        bus = 8'h00;
        if (control_word.oe_ram)
            bus = mem_data;
        else if (control_word.oe_temp_1)
            bus = temp_1;
        else if (control_word.oe_temp_2)
            bus = temp_2;
        else if (control_word.oe_alu)
            bus = alu_result;
    end

    assign alu_a    = reg_a;
    assign alu_b    = control_word.alu_src_c ? reg_c : reg_b;
    assign mem_addr = mar;

    // ========================================
    // Architectural registers
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_a  <= 8'h00;
            reg_b  <= 8'h00;
            reg_c  <= 8'h00;
            temp_1 <= 8'h00;
            temp_2 <= 8'h00;
            opcode <= cpu_pkg::NOP;
            flags  <= '0;
            pc     <= 16'h0000;
            mar    <= 16'h0000;
        end else begin
            if (control_word.load_a) reg_a <= bus;
            if (control_word.load_b) reg_b <= bus;
            if (control_word.load_c) reg_c <= bus;
            if (control_word.load_temp_1) temp_1 <= bus;
            if (control_word.load_temp_2) temp_2 <= bus;
            if (control_word.load_ir) opcode <= cpu_pkg::opcode_t'(bus);

            if (control_word.load_origin)
                pc <= cpu_pkg::ORIGIN_ADDR;
            else if (control_word.load_pc)
                pc <= {temp_2, temp_1};
            else if (control_word.pc_enable)
                pc <= pc + 16'd1;

            if (control_word.load_mar_pc) mar <= pc;
            if (control_word.load_mar_addr_low) mar[7:0] <= bus;
            if (control_word.load_mar_addr_high) mar[15:8] <= bus;

            if (control_word.load_flags) begin
                if (control_word.load_sets_zn) begin
                    flags.zero     <= (bus == 8'h00);    // Carry kept
                    flags.negative <= bus[7];
                end else begin
                    flags <= alu_flags;
                end
            end
        end
    end

endmodule

//--- src/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  cpu_pkg::opcode_t       opcode,
    input  cpu_pkg::flags_t        flags,
    output cpu_pkg::control_word_t control_word,
    output logic                   halted
);

    cpu_pkg::fsm_state_t    state;
    cpu_pkg::fsm_state_t    next_state;
    cpu_pkg::microstep_t    microstep;
    cpu_pkg::microstep_t    next_microstep;
    logic [1:0]             byte_count;       // Bytes of this instruction fetched so far
    logic [1:0]             next_byte_count;
    logic [1:0]             num_operand_bytes;
    logic                   opcode_valid;
    cpu_pkg::control_word_t rom_word;
    logic                   check_jump;
    logic                   jump_taken;

    // ========================================
    // Microcode ROM
    function automatic cpu_pkg::control_word_t microcode_rom(
        input cpu_pkg::opcode_t    op,
        input cpu_pkg::microstep_t step
    );
        cpu_pkg::control_word_t cw;
        cw = '0;
        case (op)
            cpu_pkg::NOP: begin
                cw.last_step = (step == cpu_pkg::MS0);
            end
            cpu_pkg::HLT: begin
                cw.halt = 1'b1;
            end
            cpu_pkg::ADD_B, cpu_pkg::ADD_C, cpu_pkg::SUB_B, cpu_pkg::SUB_C,
            cpu_pkg::INR_A, cpu_pkg::DCR_A: begin
                case (op)
                    cpu_pkg::ADD_B, cpu_pkg::ADD_C: cw.alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::SUB_B, cpu_pkg::SUB_C: cw.alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::INR_A:                 cw.alu_op = cpu_pkg::ALU_INC;
                    default:                        cw.alu_op = cpu_pkg::ALU_DEC;
                endcase
                cw.alu_src_c = (op == cpu_pkg::ADD_C) || (op == cpu_pkg::SUB_C);
                if (step == cpu_pkg::MS0) begin
                    cw.load_flags = 1'b1;     // Flags from ALU result
                end else if (step == cpu_pkg::MS1) begin
                    cw.oe_alu    = 1'b1;
                    cw.load_a    = 1'b1;
                    cw.last_step = 1'b1;
                end
            end
            cpu_pkg::LDI_A, cpu_pkg::LDI_B, cpu_pkg::LDI_C: begin
                if (step == cpu_pkg::MS0) begin
                    cw.oe_temp_1    = 1'b1;
                    cw.load_a       = (op == cpu_pkg::LDI_A);
                    cw.load_b       = (op == cpu_pkg::LDI_B);
                    cw.load_c       = (op == cpu_pkg::LDI_C);
                    cw.load_flags   = 1'b1;
                    cw.load_sets_zn = 1'b1;
                    cw.last_step    = 1'b1;
                end
            end
            cpu_pkg::JMP, cpu_pkg::JZ, cpu_pkg::JNZ, cpu_pkg::JN: begin
                if (step == cpu_pkg::MS0) begin
                    cw.oe_temp_1      = 1'b1;
                    cw.load_pc        = 1'b1;
                    cw.check_zero     = (op == cpu_pkg::JZ);
                    cw.check_not_zero = (op == cpu_pkg::JNZ);
                    cw.check_negative = (op == cpu_pkg::JN);
                    cw.last_step      = 1'b1;
                end
            end
            cpu_pkg::LDA: begin
                case (step)
                    cpu_pkg::MS0: cw.oe_temp_1 = 1'b1;
                    cpu_pkg::MS1: begin
                        cw.oe_temp_1         = 1'b1;
                        cw.load_mar_addr_low = 1'b1;
                    end
                    cpu_pkg::MS2: cw.oe_temp_2 = 1'b1;
                    cpu_pkg::MS3: begin
                        cw.oe_temp_2          = 1'b1;
                        cw.load_mar_addr_high = 1'b1;
                    end
                    cpu_pkg::MS4: cw.oe_ram = 1'b1;     // MAR now points at data
                    cpu_pkg::MS5: begin
                        cw.oe_ram       = 1'b1;
                        cw.load_a       = 1'b1;
                        cw.load_flags   = 1'b1;
                        cw.load_sets_zn = 1'b1;
                        cw.last_step    = 1'b1;
                    end
                    default: cw.halt = 1'b1;
                endcase
            end
            default: begin
                cw.halt = 1'b1;
            end
        endcase
        return cw;
    endfunction

    // ========================================
    // Operand count decode
    always_comb begin
        opcode_valid = 1'b1;
        case (opcode)
            cpu_pkg::NOP, cpu_pkg::HLT, cpu_pkg::ADD_B, cpu_pkg::ADD_C,
            cpu_pkg::SUB_B, cpu_pkg::SUB_C, cpu_pkg::INR_A, cpu_pkg::DCR_A:
                num_operand_bytes = 2'd0;
            cpu_pkg::LDI_A, cpu_pkg::LDI_B, cpu_pkg::LDI_C:
                num_operand_bytes = 2'd1;
            cpu_pkg::JMP, cpu_pkg::JZ, cpu_pkg::JNZ, cpu_pkg::JN, cpu_pkg::LDA:
                num_operand_bytes = 2'd2;
            default: begin
                num_operand_bytes = 2'd0;
                opcode_valid      = 1'b0;
            end
        endcase
    end

    assign rom_word   = microcode_rom(opcode, microstep);
    assign check_jump = rom_word.check_zero || rom_word.check_not_zero ||
                        rom_word.check_carry || rom_word.check_negative;
    assign jump_taken = (rom_word.check_zero     &&  flags.zero)  ||
                        (rom_word.check_not_zero && !flags.zero)  ||
                        (rom_word.check_carry    &&  flags.carry) ||
                        (rom_word.check_negative &&  flags.negative);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= cpu_pkg::S_RESET;
            microstep  <= cpu_pkg::MS0;
            byte_count <= 2'd0;
        end else begin
            state      <= next_state;
            microstep  <= next_microstep;
            byte_count <= next_byte_count;
        end
    end

    // ========================================
    // Next state and control word
    always_comb begin
        next_state      = state;
        next_microstep  = microstep;
        next_byte_count = byte_count;
        control_word    = '0;
        case (state)
            cpu_pkg::S_RESET: next_state = cpu_pkg::S_INIT;
            cpu_pkg::S_INIT: begin
                control_word.load_origin = 1'b1;
                next_state               = cpu_pkg::S_LATCH_ADDR;
            end
            cpu_pkg::S_LATCH_ADDR: begin
                control_word.load_mar_pc = 1'b1;
                next_state               = cpu_pkg::S_READ_BYTE;
            end
            cpu_pkg::S_READ_BYTE: begin
                control_word.oe_ram = 1'b1;
                next_state          = cpu_pkg::S_LATCH_BYTE;
            end
            cpu_pkg::S_LATCH_BYTE: begin
                if (byte_count == 2'd3) begin
                    next_state      = cpu_pkg::S_HALT;    // Byte count overflow
                    next_byte_count = 2'd0;
                end else begin
                    control_word.oe_ram      = 1'b1;
                    control_word.pc_enable   = 1'b1;
                    control_word.load_ir     = (byte_count == 2'd0);
                    control_word.load_temp_1 = (byte_count == 2'd1);
                    control_word.load_temp_2 = (byte_count == 2'd2);
                    next_state               = cpu_pkg::S_CHK_MORE_BYTES;
                    next_byte_count          = byte_count + 2'd1;
                end
            end
            cpu_pkg::S_CHK_MORE_BYTES: begin
                if (!opcode_valid) begin
                    next_state = cpu_pkg::S_HALT;
                end else if (byte_count > num_operand_bytes) begin
                    next_state      = cpu_pkg::S_EXECUTE;
                    next_byte_count = 2'd0;
                end else begin
                    next_state = cpu_pkg::S_LATCH_ADDR;
                end
            end
            cpu_pkg::S_EXECUTE: begin
                control_word = rom_word;
                if (rom_word.halt) begin
                    next_state     = cpu_pkg::S_HALT;
                    next_microstep = cpu_pkg::MS0;
                end else if (check_jump && !jump_taken) begin
                    control_word.load_pc = 1'b0;    // PC already past the operands
                    next_state           = cpu_pkg::S_LATCH_ADDR;
                    next_microstep       = cpu_pkg::MS0;
                end else if (rom_word.last_step) begin
                    next_state     = cpu_pkg::S_LATCH_ADDR;
                    next_microstep = cpu_pkg::MS0;
                end else begin
                    next_microstep = cpu_pkg::microstep_t'(microstep + 1'b1);
                end
            end
            default: next_state = cpu_pkg::S_HALT;    // Control word stays zero
        endcase
    end

    assign halted = (state == cpu_pkg::S_HALT);

endmodule

//--- src/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic            clk,
    input  logic            reset,
    input  logic            prog_we,
    input  logic [7:0]      prog_addr,
    input  logic [7:0]      prog_data,
    output logic            halted,
    output logic [7:0]      reg_a,
    output logic [7:0]      reg_b,
    output logic [7:0]      reg_c,
    output cpu_pkg::flags_t flags,
    output logic [15:0]     pc
);

    cpu_pkg::control_word_t control_word;
    cpu_pkg::opcode_t       opcode;
    cpu_pkg::flags_t        alu_flags;
    logic [15:0]            mem_addr;
    logic [7:0]             mem_data;
    logic [7:0]             alu_a;
    logic [7:0]             alu_b;
    logic [7:0]             alu_result;

    control_unit control_unit_inst (
        .clk          (clk),
        .reset        (reset),
        .opcode       (opcode),
        .flags        (flags),
        .control_word (control_word),
        .halted       (halted)
    );

    datapath datapath_inst (
        .clk          (clk),
        .reset        (reset),
        .control_word (control_word),
        .mem_data     (mem_data),
        .alu_result   (alu_result),
        .alu_flags    (alu_flags),
        .mem_addr     (mem_addr),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .opcode       (opcode),
        .flags        (flags),
        .reg_a        (reg_a),
        .reg_b        (reg_b),
        .reg_c        (reg_c),
        .pc           (pc)
    );

    alu alu_inst (
        .a            (alu_a),
        .b            (alu_b),
        .alu_op       (control_word.alu_op),
        .result       (alu_result),
        .result_flags (alu_flags)
    );

    ram ram_inst (
        .clk       (clk),
        .addr      (mem_addr),
        .rdata     (mem_data),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data)
    );

endmodule

//--- tests/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    localparam int RESET_CYCLES = 8;
    localparam int HALT_TIMEOUT = 2000;    // Cycles allowed from reset release to halt
    localparam int HOLD_CYCLES  = 10;

    logic            clk;
    logic            reset;
    logic            prog_we;
    logic [7:0]      prog_addr;
    logic [7:0]      prog_data;
    logic            halted;
    logic [7:0]      reg_a;
    logic [7:0]      reg_b;
    logic [7:0]      reg_c;
    cpu_pkg::flags_t flags;
    logic [15:0]     pc;

    logic [7:0] prog [256];    // Program image of the current test
    int         error_count;
    int         test_count;
    int         pass_count;
    int         fail_count;

    cpu_top cpu_top_inst (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .halted    (halted),
        .reg_a     (reg_a),
        .reg_b     (reg_b),
        .reg_c     (reg_c),
        .flags     (flags),
        .pc        (pc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ========================================
    // Compare tasks
    task automatic check_byte(input string test, input string signal,
                              input logic [7:0] actual, input logic [7:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s %s: got 0x%02h, expected 0x%02h", test, signal, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_flags(input string test, input cpu_pkg::flags_t actual,
                               input cpu_pkg::flags_t expected);
        if (actual !== expected) begin
            $display("FAILED %s flags: got 0x%01h, expected 0x%01h", test, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_pc(input string test, input logic [15:0] actual,
                            input logic [15:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s pc: got 0x%04h, expected 0x%04h", test, actual, expected);
            error_count++;
        end
    endtask

    // ========================================
    // Program load and run
    task automatic drive_load_port(input int cycle, input int count);
        if (cycle < count) begin
            prog_we   = 1'b1;
            prog_addr = cycle[7:0];
            prog_data = prog[cycle];
        end else begin
            prog_we = 1'b0;
        end
    endtask

    task automatic load_program(input int count);
        int last;
        last  = (count > RESET_CYCLES) ? count : RESET_CYCLES;    // Longer images stretch reset
        reset = 1'b1;
        drive_load_port(0, count);
        for (int cycle = 1; cycle < last; cycle++) begin
            @(posedge clk);
            #1;
            drive_load_port(cycle, count);
        end
        @(posedge clk);
        #1;
        prog_we = 1'b0;
        reset   = 1'b0;
    endtask

    task automatic run_test(input string name, input int count,
                            input logic [7:0] exp_a, input logic [7:0] exp_b,
                            input logic [7:0] exp_c, input cpu_pkg::flags_t exp_flags,
                            input logic [15:0] exp_pc);
        int   cycles;
        int   errors_before;
        logic dropped;
        errors_before = error_count;
        dropped       = 1'b0;
        load_program(count);
        cycles = 0;
        while (!halted && cycles < HALT_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!halted) begin
            $display("%s: timeout waiting for halt", name);
            error_count++;
        end else begin
            repeat (HOLD_CYCLES) begin    // State must hold while halted
                @(posedge clk);
                #1;
                if (!halted)
                    dropped = 1'b1;
            end
            if (dropped) begin
                $display("%s: halted went low again after the CPU halted", name);
                error_count++;
            end
            check_byte(name, "reg_a", reg_a, exp_a);
            check_byte(name, "reg_b", reg_b, exp_b);
            check_byte(name, "reg_c", reg_c, exp_c);
            check_flags(name, flags, exp_flags);
            check_pc(name, pc, exp_pc);
        end
        test_count++;
        if (error_count == errors_before) begin
            pass_count++;
            $display("%-16s passed", name);
        end else begin
            fail_count++;
            $display("%-16s failed", name);
        end
    endtask

    // ========================================
    // Pattern file loop
    initial begin : main_sequence
        int          fd;
        int          code;
        int          count;
        logic        done;
        logic        bad;
        logic [31:0] word;
        logic [7:0]  exp_a;
        logic [7:0]  exp_b;
        logic [7:0]  exp_c;
        logic [7:0]  exp_flags;
        logic [15:0] exp_pc;
        string       name;
        string       line;
        reset       = 1'b1;
        prog_we     = 1'b0;
        prog_addr   = 8'h00;
        prog_data   = 8'h00;
        error_count = 0;
        test_count  = 0;
        pass_count  = 0;
        fail_count  = 0;
        done        = 1'b0;
        @(posedge clk);
        #1;
        fd = $fopen("tests/cpu_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/cpu_patterns.txt");
            fail_count++;
            done = 1'b1;
        end
        while (!done) begin
            code = $fscanf(fd, "%s", name);
            if (code != 1) begin
                done = 1'b1;
            end else if (name.substr(0, 0) == "#") begin
                code = $fgets(line, fd);    // Skip comment line
            end else begin
                code = $fscanf(fd, "%d", count);
                bad  = (code != 1) || (count < 1) || (count > 256);
                for (int i = 0; i < count && !bad; i++) begin
                    code    = $fscanf(fd, "%h", word);
                    bad     = bad || (code != 1);
                    prog[i] = word[7:0];
                end
                code = $fscanf(fd, "%h %h %h %h %h", exp_a, exp_b, exp_c, exp_flags, exp_pc);
                bad  = bad || (code != 5);
                if (bad) begin
                    $display("pattern line for %s could not be read", name);
                    fail_count++;
                    done = 1'b1;
                end else begin
                    run_test(name, count, exp_a, exp_b, exp_c,
                             cpu_pkg::flags_t'(exp_flags[2:0]), exp_pc);
                end
            end
        end
        if (fd != 0)
            $fclose(fd);
        if (test_count == 0)
            $display("no test patterns were run");
        $display("tests run: %0d, passed: %0d, failed: %0d", test_count, pass_count, fail_count);
        if (fail_count == 0 && test_count > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tests/cpu_patterns.txt
# name count(decimal) program bytes(hex) then expected reg_a reg_b reg_c flags pc (hex)
# flags is {negative, carry, zero} with zero in bit 0
ldi_basic        7  08 12 09 34 0A 00 01            12 34 00 1 0007
ldi_carry_kept   8  08 FF 09 01 02 0A 80 01         00 01 80 6 0008
add_b_carry      6  08 F0 09 20 02 01               10 20 00 2 0006
add_c_carry      6  08 80 0A 80 03 01               00 00 80 3 0006
sub_b_zero       6  08 42 09 42 04 01               00 42 00 1 0006
sub_c_borrow     6  08 05 0A 07 05 01               FE 00 07 6 0006
inr_a_wrap       4  08 FF 06 01                     00 00 00 3 0004
dcr_a_wrap       4  08 00 07 01                     FF 00 00 6 0004
jmp_skip         8  09 11 0B 07 00 09 22 01         00 11 00 0 0008
jz_taken         9  08 00 0C 08 00 09 22 01 01      00 00 00 1 0009
jz_not_taken     9  08 01 0C 08 00 09 22 01 01      01 22 00 0 0008
jnz_taken        9  08 01 0D 08 00 09 22 01 01      01 00 00 0 0009
jnz_not_taken    9  08 00 0D 08 00 09 22 01 01      00 22 00 0 0008
jn_taken         9  08 90 0E 08 00 09 22 01 01      90 00 00 4 0009
jn_not_taken     9  08 10 0E 08 00 09 22 01 01      10 22 00 0 0008
lda_negative     5  0F 04 00 01 9C                  9C 00 00 4 0004
lda_zero         7  08 55 0F 06 00 01 00            00 00 00 1 0006
lda_high_addr    5  0F 04 01 01 7F                  7F 00 00 0 0004
nop_hlt          5  00 00 08 01 01                  01 00 00 0 0005
unknown_opcode   6  08 33 20 09 44 01               33 00 00 0 0003

//--- tb.f
src/cpu_pkg.sv
src/alu.sv
src/ram.sv
src/datapath.sv
src/control_unit.sv
src/cpu_top.sv
tests/cpu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cpu_tb -f tb.f -o cpu_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/cpu_tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
